// ==== Bender.yml ====
package:
  name: dcache

sources:
  - rtl/mem_bus_pkg.sv
  - rtl/dcache_pkg.sv
  - rtl/dcache_req_decode.sv
  - rtl/dcache_line_ram.sv
  - rtl/dcache_ctrl.sv
  - rtl/dcache_resp.sv
  - rtl/dcache_top.sv
  - target: test
    files:
      - verif/tb_dcache.sv

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire logic i_request,
	input wire logic i_rw,
	input wire logic i_flush,
	input wire logic i_cacheable,
	input wire mem_bus_pkg::bus_addr_t i_address,
	input wire mem_bus_pkg::bus_data_t i_wdata,
	input wire logic i_initialized,
	input wire dcache_pkg::entry_index_t i_index,
	input wire logic i_hit,
	input wire logic i_victim_dirty,
	input wire logic i_dirty,
	input wire mem_bus_pkg::bus_addr_t i_victim_address,
	input wire mem_bus_pkg::bus_data_t i_victim_data,
	input wire logic i_bus_ready,
	input wire mem_bus_pkg::bus_data_t i_bus_rdata,
	output logic o_bus_request,
	output logic o_bus_rw,
	output mem_bus_pkg::bus_addr_t o_bus_address,
	output mem_bus_pkg::bus_data_t o_bus_wdata,
	output logic o_ram_write,
	output dcache_pkg::entry_index_t o_ram_index,
	output dcache_pkg::line_entry_t o_ram_entry,
	output logic o_done_strobe,
	output mem_bus_pkg::bus_data_t o_done_data
);

	import mem_bus_pkg::*;
	import dcache_pkg::*;

	localparam entry_index_t LAST_INDEX = entry_index_t'(ENTRIES - 1);

	dcache_state_t state;
	entry_index_t flush_index;
	logic done_dly;
	logic accept;
	logic flush_step;
	logic [WORD_ADDR_W-1:0] req_word;
	logic [WORD_ADDR_W-1:0] victim_word;

	// The CPU keeps its request up until o_ready, so ignore it while
	// the completion is still travelling through the response stage.
	assign accept = i_request && !o_done_strobe && !done_dly;

	// Current flush entry is finished.
	assign flush_step = (state == ST_FL_CHECK && !i_dirty)
		|| (state == ST_FL_WRITE && i_bus_ready);

	assign req_word = i_address[BUS_ADDR_W-1:WORD_LSB];
	assign victim_word = i_victim_address[BUS_ADDR_W-1:WORD_LSB];

	// ============================================================
	// Sequencer and registered bus outputs.
	// ============================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			flush_index <= '0;
			done_dly <= 1'b0;
			o_bus_request <= 1'b0;
			o_bus_rw <= 1'b0;
			o_bus_address <= '0;
			o_bus_wdata <= '0;
			o_done_strobe <= 1'b0;
			o_done_data <= '0;
		end else begin
			o_done_strobe <= 1'b0;
			done_dly <= o_done_strobe;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						if (i_flush) begin
							if (i_initialized) begin
								flush_index <= '0;
								state <= ST_FL_SETUP;
							end else begin
								// Nothing cached yet.
								o_done_strobe <= 1'b1;
							end
						end else if (i_initialized && i_cacheable) begin
							state <= i_rw ? ST_WR_LOOKUP : ST_RD_LOOKUP;
						end else begin
							o_bus_request <= 1'b1;
							o_bus_rw <= i_rw;
							o_bus_address <= i_address;
							o_bus_wdata <= i_wdata;
							state <= ST_PASS;
						end
					end
				end
				ST_PASS: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_done_strobe <= 1'b1;
						o_done_data <= i_rw ? i_wdata : i_bus_rdata;
						state <= ST_IDLE;
					end
				end
				ST_RD_LOOKUP: begin
					if (i_hit) begin
						o_done_strobe <= 1'b1;
						o_done_data <= i_victim_data;
						state <= ST_IDLE;
					end else if (i_victim_dirty) begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b1;
						o_bus_address <= i_victim_address;
						o_bus_wdata <= i_victim_data;
						state <= ST_RD_WB;
					end else begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b0;
						o_bus_address <= i_address;
						state <= ST_RD_REFILL;
					end
				end
				// Once the victim is accepted the refill read follows right away.
				ST_RD_WB: begin
					if (i_bus_ready) begin
						o_bus_rw <= 1'b0;
						o_bus_address <= i_address;
						state <= ST_RD_REFILL;
					end
				end
				ST_RD_REFILL: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_done_strobe <= 1'b1;
						o_done_data <= i_bus_rdata;
						state <= ST_IDLE;
					end
				end
				ST_WR_LOOKUP: begin
					if (i_victim_dirty) begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b1;
						o_bus_address <= i_victim_address;
						o_bus_wdata <= i_victim_data;
						state <= ST_WR_WB;
					end else begin
						o_done_strobe <= 1'b1;
						o_done_data <= i_wdata;
						state <= ST_IDLE;
					end
				end
				ST_WR_WB: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_done_strobe <= 1'b1;
						o_done_data <= i_wdata;
						state <= ST_IDLE;
					end
				end
				ST_FL_SETUP: begin
					state <= ST_FL_CHECK;
				end
				ST_FL_CHECK: begin
					if (i_dirty) begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b1;
						o_bus_address <= i_victim_address;
						o_bus_wdata <= i_victim_data;
						state <= ST_FL_WRITE;
					end
				end
				ST_FL_WRITE: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase

			// Move the sweep on, or finish after the last entry.
			if (flush_step) begin
				if (flush_index == LAST_INDEX) begin
					o_done_strobe <= 1'b1;
					state <= ST_IDLE;
				end else begin
					flush_index <= flush_index + 1'b1;
					state <= ST_FL_SETUP;
				end
			end
		end
	end

	// ============================================================
	// Line RAM port.
	// ============================================================

	always_comb begin
		o_ram_index = i_index;
		o_ram_write = 1'b0;
		o_ram_entry = LINE_CLEARED;
		case (state)
			ST_RD_REFILL: begin
				o_ram_write = i_bus_ready;
				o_ram_entry = '{data: i_bus_rdata, word_addr: req_word, dirty: 1'b0, valid: 1'b1};
			end
			ST_WR_LOOKUP, ST_WR_WB: begin
				o_ram_write = (state == ST_WR_LOOKUP) ? !i_victim_dirty : i_bus_ready;
				o_ram_entry = '{data: i_wdata, word_addr: req_word, dirty: 1'b1, valid: 1'b1};
			end
			ST_FL_SETUP, ST_FL_CHECK: begin
				o_ram_index = flush_index;
			end
			// A written back entry stays valid and turns clean.
			ST_FL_WRITE: begin
				o_ram_index = flush_index;
				o_ram_write = i_bus_ready;
				o_ram_entry = '{data: i_victim_data, word_addr: victim_word,
					dirty: 1'b0, valid: 1'b1};
			end
			default: begin
				o_ram_write = 1'b0;
			end
		endcase
	end

	// Bus transfer held until accepted.
	a_bus_hold: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_rw)
			&& $stable(o_bus_address) && $stable(o_bus_wdata))
	);

	a_done_pulse: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		o_done_strobe |=> !o_done_strobe
	);

endmodule

`default_nettype wire

// ==== rtl/dcache_line_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_line_ram (
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire logic i_write,
	input wire dcache_pkg::entry_index_t i_index,
	input wire dcache_pkg::line_entry_t i_entry,
	output dcache_pkg::line_entry_t o_entry,
	output logic o_initialized
);

	import dcache_pkg::*;

	localparam entry_index_t LAST_INDEX = entry_index_t'(ENTRIES - 1);

	logic [ENTRY_W-1:0] mem [ENTRIES];
	entry_index_t clear_index;

	// ============================================================
	// Clearing sweep after reset at one entry per cycle.
	// ============================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			clear_index <= '0;
			o_initialized <= 1'b0;
		end else if (!o_initialized) begin
			clear_index <= clear_index + 1'b1;
			if (clear_index == LAST_INDEX) begin
				o_initialized <= 1'b1;
			end
		end
	end

	// Port writes are ignored until the sweep ends.
	always_ff @(posedge i_clock) begin
		if (!o_initialized) begin
			mem[clear_index] <= LINE_CLEARED;
		end else if (i_write) begin
			mem[i_index] <= i_entry;
		end
	end

	// Registered read one cycle behind the index.
	always_ff @(posedge i_clock) begin
		o_entry <= line_entry_t'(mem[i_index]);
	end

	// Once up, the memory stays initialized until the next reset.
	a_init_sticky: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		o_initialized |=> o_initialized
	);

endmodule

`default_nettype wire

// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

	// ============================================================
	// Cache geometry.
	// ============================================================

	// 64 entries keeps random test addresses colliding often.
	localparam int INDEX_W = 6;
	localparam int ENTRIES = 1 << INDEX_W;
	localparam int ENTRY_W = 64;

	// Word address kept in each entry.
	localparam int WORD_ADDR_W = mem_bus_pkg::BUS_ADDR_W - mem_bus_pkg::WORD_LSB;

	typedef logic [INDEX_W-1:0] entry_index_t;

	// ============================================================
	// Line entry layout with the flags in the low bits.
	// ============================================================

	typedef struct packed {
		mem_bus_pkg::bus_data_t data;
		logic [WORD_ADDR_W-1:0] word_addr;
		logic dirty;
		logic valid;
	} line_entry_t;

	// Invalid and clean.
	localparam line_entry_t LINE_CLEARED = '0;

	// Controller states.
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_PASS,
		ST_RD_LOOKUP,
		ST_RD_WB,
		ST_RD_REFILL,
		ST_WR_LOOKUP,
		ST_WR_WB,
		ST_FL_SETUP,
		ST_FL_CHECK,
		ST_FL_WRITE
	} dcache_state_t;

endpackage

`default_nettype wire

// ==== rtl/dcache_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_req_decode (
	input wire mem_bus_pkg::bus_addr_t i_address,
	input wire dcache_pkg::line_entry_t i_entry,
	output dcache_pkg::entry_index_t o_index,
	output logic o_hit,
	output logic o_victim_dirty,
	output logic o_dirty,
	output mem_bus_pkg::bus_addr_t o_victim_address,
	output mem_bus_pkg::bus_data_t o_victim_data
);

	import mem_bus_pkg::*;
	import dcache_pkg::*;

	logic [WORD_ADDR_W-1:0] req_word;
	logic addr_match;

	// Word address of the request without the byte bits.
	assign req_word = i_address[BUS_ADDR_W-1:WORD_LSB];

	// Low word-address bits pick the entry in the direct-mapped array.
	assign o_index = req_word[INDEX_W-1:0];

	assign addr_match = (i_entry.word_addr == req_word);

	// ============================================================
	// Lookup flags.
	// ============================================================

	assign o_hit = i_entry.valid && addr_match;

	// A dirty entry for another address must go out first.
	assign o_victim_dirty = i_entry.dirty && !addr_match;

	// Raw dirty flag for the flush sweep.
	assign o_dirty = i_entry.dirty;

	// Stored entry rebuilt as a bus transfer.
	assign o_victim_address = {i_entry.word_addr, {WORD_LSB{1'b0}}};
	assign o_victim_data = i_entry.data;

endmodule

`default_nettype wire

// ==== rtl/dcache_resp.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_resp (
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire logic i_done_strobe,
	input wire mem_bus_pkg::bus_data_t i_done_data,
	output logic o_ready,
	output mem_bus_pkg::bus_data_t o_rdata
);

	// ============================================================
	// Completion stage toward the CPU.
	// ============================================================

	// One cycle pulse that follows the done strobe.
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ready <= 1'b0;
		end else begin
			o_ready <= i_done_strobe;
		end
	end

	// Read data held until the next completion.
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_rdata <= '0;
		end else if (i_done_strobe) begin
			o_rdata <= i_done_data;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire logic i_request,
	input wire logic i_rw,
	input wire logic i_flush,
	input wire logic i_cacheable,
	input wire mem_bus_pkg::bus_addr_t i_address,
	input wire mem_bus_pkg::bus_data_t i_wdata,
	output logic o_ready,
	output mem_bus_pkg::bus_data_t o_rdata,
	output logic o_bus_request,
	output logic o_bus_rw,
	output mem_bus_pkg::bus_addr_t o_bus_address,
	output mem_bus_pkg::bus_data_t o_bus_wdata,
	input wire logic i_bus_ready,
	input wire mem_bus_pkg::bus_data_t i_bus_rdata
);

	import mem_bus_pkg::*;
	import dcache_pkg::*;

	entry_index_t req_index;
	entry_index_t ram_index;
	line_entry_t ram_rentry;
	line_entry_t ram_wentry;
	logic ram_write;
	logic initialized;
	logic hit;
	logic victim_dirty;
	logic entry_dirty;
	bus_addr_t victim_address;
	bus_data_t victim_data;
	logic done_strobe;
	bus_data_t done_data;

	dcache_req_decode dcache_req_decode_inst (
		.i_address(i_address),
		.i_entry(ram_rentry),
		.o_index(req_index),
		.o_hit(hit),
		.o_victim_dirty(victim_dirty),
		.o_dirty(entry_dirty),
		.o_victim_address(victim_address),
		.o_victim_data(victim_data)
	);

	dcache_line_ram dcache_line_ram_inst (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_write(ram_write),
		.i_index(ram_index),
		.i_entry(ram_wentry),
		.o_entry(ram_rentry),
		.o_initialized(initialized)
	);

	dcache_ctrl dcache_ctrl_inst (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_flush(i_flush),
		.i_cacheable(i_cacheable),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_initialized(initialized),
		.i_index(req_index),
		.i_hit(hit),
		.i_victim_dirty(victim_dirty),
		.i_dirty(entry_dirty),
		.i_victim_address(victim_address),
		.i_victim_data(victim_data),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.o_ram_write(ram_write),
		.o_ram_index(ram_index),
		.o_ram_entry(ram_wentry),
		.o_done_strobe(done_strobe),
		.o_done_data(done_data)
	);

	dcache_resp dcache_resp_inst (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_done_strobe(done_strobe),
		.i_done_data(done_data),
		.o_ready(o_ready),
		.o_rdata(o_rdata)
	);

endmodule

`default_nettype wire

// ==== rtl/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

	// ============================================================
	// Bus geometry shared by the CPU port and the memory bus.
	// ============================================================

	localparam int BUS_ADDR_W = 32;
	localparam int BUS_DATA_W = 32;

	// Byte-select bits below the word address.
	localparam int WORD_LSB = 2;

	typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
	typedef logic [BUS_DATA_W-1:0] bus_data_t;

endpackage

`default_nettype wire

// ==== src.f ====
rtl/mem_bus_pkg.sv
rtl/dcache_pkg.sv
rtl/dcache_req_decode.sv
rtl/dcache_line_ram.sv
rtl/dcache_ctrl.sv
rtl/dcache_resp.sv
rtl/dcache_top.sv
verif/tb_dcache.sv

// ==== verif/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	import mem_bus_pkg::*;
	import dcache_pkg::*;

	localparam int SEED = 32'h38e7;
	localparam int RESET_CYCLES = 8;
	localparam int N_OPS = 400;
	localparam int N_HIT = 8;
	localparam int N_EARLY = 6;
	// Cached traffic stays in the first 1 KB, uncached traffic in the next 1 KB.
	localparam int CACHE_WORDS = 256;
	localparam int MEM_WORDS = 512;
	localparam bus_addr_t UNCACHED_BASE = 32'h0000_0400;
	localparam bus_addr_t MEM_BYTES = 32'h0000_0800;
	localparam int TOTAL_OPS = N_OPS + 2 * N_HIT + N_EARLY + 3;
	// Worst case per flush entry covers check, write, bus wait and setup.
	localparam int FLUSH_ALLOW = ENTRIES * 12;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * ENTRIES + TOTAL_OPS * 40
		+ 3 * FLUSH_ALLOW;

	logic i_clock;
	logic i_arst_n;
	logic i_request;
	logic i_rw;
	logic i_flush;
	logic i_cacheable;
	bus_addr_t i_address;
	bus_data_t i_wdata;
	logic o_ready;
	bus_data_t o_rdata;
	logic o_bus_request;
	logic o_bus_rw;
	bus_addr_t o_bus_address;
	bus_data_t o_bus_wdata;
	logic i_bus_ready;
	bus_data_t i_bus_rdata;

	integer seed = SEED;
	integer bus_seed = SEED ^ 32'h5a5a;
	int bus_count = 0;
	bit passthru_op = 1'b0;
	bus_addr_t last_bus_addr;
	logic last_bus_rw;
	bus_data_t last_bus_wdata;

	// Memory behind the bus and the expected CPU view of it.
	bus_data_t bus_mem [MEM_WORDS];
	bus_data_t ref_mem [MEM_WORDS];

	dcache_top dcache_top_inst (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_flush(i_flush),
		.i_cacheable(i_cacheable),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	// ============================================================
	// Compare tasks.
	// ============================================================

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input bus_addr_t exp, input bus_addr_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	// Golden-ratio multiply so every address bit changes the word.
	function automatic bus_data_t fill_word(input int idx);
		return bus_data_t'(idx * 32'h9e37_79b1) ^ 32'h5ac3_0000;
	endfunction

	function automatic bus_addr_t rand_cached_addr();
		return bus_addr_t'(($unsigned($random(seed)) % CACHE_WORDS) << WORD_LSB);
	endfunction

	function automatic bus_addr_t rand_uncached_addr();
		return UNCACHED_BASE + bus_addr_t'(($unsigned($random(seed)) % CACHE_WORDS) << WORD_LSB);
	endfunction

	// Runs one CPU request from the drive to the o_ready pulse and one idle cycle.
	// exp_bus is the number of bus transfers expected, or -1 for any.
	task automatic run_op(input string name, input logic rw, input logic flush,
		input logic cacheable, input bus_addr_t addr, input bus_data_t wdata,
		input bit passthru, input int exp_bus, output int cycles);
		int bus_before;
		int widx;
		bus_before = bus_count;
		widx = int'(addr >> WORD_LSB);
		passthru_op = passthru;
		i_request = 1'b1;
		i_rw = rw;
		i_flush = flush;
		i_cacheable = cacheable;
		i_address = addr;
		i_wdata = wdata;
		cycles = 0;
		do begin
			@(posedge i_clock);
			#1;
			cycles++;
		end while (!o_ready);
		i_request = 1'b0;
		i_flush = 1'b0;
		if (!flush) begin
			if (rw) begin
				ref_mem[widx] = wdata;
			end else begin
				check_data({name, " read data"}, ref_mem[widx], o_rdata);
			end
		end
		if (exp_bus >= 0) begin
			check_count({name, " bus transfers"}, exp_bus, bus_count - bus_before);
		end
		if (passthru && !flush) begin
			check_addr({name, " bus address"}, addr, last_bus_addr);
			check_flag({name, " bus direction"}, rw, last_bus_rw);
			if (rw) begin
				check_data({name, " bus write data"}, wdata, last_bus_wdata);
			end
		end
		passthru_op = 1'b0;
		@(posedge i_clock);
		#1;
	endtask

	// ============================================================
	// Bus memory model.
	// ============================================================

	initial begin : bus_model
		int waits;
		int widx;
		waits = -1;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		for (int k = 0; k < MEM_WORDS; k++) begin
			bus_mem[k] = fill_word(k);
			ref_mem[k] = fill_word(k);
		end
		forever begin
			@(posedge i_clock);
			#1;
			if (i_bus_ready) begin
				i_bus_ready = 1'b0;
			end else if (o_bus_request) begin
				if (waits < 0) begin
					waits = $unsigned($random(bus_seed)) % 4;
				end
				if (waits == 0) begin
					if (o_bus_address >= MEM_BYTES || o_bus_address[WORD_LSB-1:0] != '0) begin
						$display("Bus address %h is outside the test memory.", o_bus_address);
						stop_run();
					end
					widx = int'(o_bus_address >> WORD_LSB);
					if (o_bus_rw) begin
						// Write-backs must carry the latest CPU data.
						if (!passthru_op) begin
							check_data("bus write-back data", ref_mem[widx], o_bus_wdata);
						end
						bus_mem[widx] = o_bus_wdata;
					end else begin
						i_bus_rdata = bus_mem[widx];
					end
					last_bus_addr = o_bus_address;
					last_bus_rw = o_bus_rw;
					last_bus_wdata = o_bus_wdata;
					bus_count++;
					i_bus_ready = 1'b1;
				end
				waits--;
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge i_clock);
		$display("Timeout, the DUT stopped completing requests.");
		$display("Testbench failed");
		$fatal(1, "Watchdog expired.");
	end

	// ============================================================
	// Test sequence.
	// ============================================================

	initial begin
		int cycles;
		int r;
		bus_addr_t a;
		bus_data_t d;
		i_arst_n = 1'b0;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_flush = 1'b0;
		i_cacheable = 1'b0;
		i_address = '0;
		i_wdata = '0;
		repeat (RESET_CYCLES) @(posedge i_clock);
		#1;
		i_arst_n = 1'b1;

		// Outputs idle before any request.
		repeat (3) begin
			@(posedge i_clock);
			#1;
			check_flag("reset o_ready", 1'b0, o_ready);
			check_flag("reset o_bus_request", 1'b0, o_bus_request);
			check_data("reset o_rdata", '0, o_rdata);
			check_addr("reset o_bus_address", '0, o_bus_address);
		end

		// Line RAM still clearing, so everything goes straight to the bus.
		a = rand_uncached_addr();
		run_op("early uncached read", 1'b0, 1'b0, 1'b0, a, '0, 1'b1, 1, cycles);
		a = rand_cached_addr();
		d = $random(seed);
		run_op("early cached write", 1'b1, 1'b0, 1'b1, a, d, 1'b1, 1, cycles);
		run_op("early cached read", 1'b0, 1'b0, 1'b1, a, '0, 1'b1, 1, cycles);
		a = rand_uncached_addr();
		d = $random(seed);
		run_op("early uncached write", 1'b1, 1'b0, 1'b0, a, d, 1'b1, 1, cycles);
		run_op("early uncached read back", 1'b0, 1'b0, 1'b0, a, '0, 1'b1, 1, cycles);
		run_op("early flush", 1'b0, 1'b1, 1'b1, '0, '0, 1'b0, 0, cycles);

		repeat (ENTRIES) @(posedge i_clock);
		#1;

		// Mixed random traffic with a flush halfway.
		for (int i = 0; i < N_OPS; i++) begin
			if (i == N_OPS / 2) begin
				run_op("mid flush", 1'b0, 1'b1, 1'b1, '0, '0, 1'b0, -1, cycles);
			end
			r = $unsigned($random(seed)) % 10;
			d = $random(seed);
			if (r == 0) begin
				a = rand_uncached_addr();
				run_op($sformatf("op %0d uncached", i), d[0], 1'b0, 1'b0, a, d,
					1'b1, 1, cycles);
			end else if (r < 5) begin
				a = rand_cached_addr();
				run_op($sformatf("op %0d read", i), 1'b0, 1'b0, 1'b1, a, '0,
					1'b0, -1, cycles);
			end else begin
				a = rand_cached_addr();
				run_op($sformatf("op %0d write", i), 1'b1, 1'b0, 1'b1, a, d,
					1'b0, -1, cycles);
			end
		end

		// A second read of the same word must hit in fixed time.
		for (int k = 0; k < N_HIT; k++) begin
			a = rand_cached_addr();
			run_op($sformatf("hit %0d prime", k), 1'b0, 1'b0, 1'b1, a, '0,
				1'b0, -1, cycles);
			run_op($sformatf("hit %0d repeat", k), 1'b0, 1'b0, 1'b1, a, '0,
				1'b0, 0, cycles);
			check_count($sformatf("hit %0d latency", k), 3, cycles);
		end

		run_op("final flush", 1'b0, 1'b1, 1'b1, '0, '0, 1'b0, -1, cycles);
		for (int k = 0; k < CACHE_WORDS; k++) begin
			check_data($sformatf("flushed word %0d", k), ref_mem[k], bus_mem[k]);
		end
		run_op("repeated flush", 1'b0, 1'b1, 1'b1, '0, '0, 1'b0, 0, cycles);

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
